/* cmd_decode.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module cmd_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      put_valid,
    input  slot_store_pkg::put_req_t  put,
    input  logic                      get_valid,
    input  slot_store_pkg::get_req_t  get,
    output slot_store_pkg::mem_port_t port_a,
    output slot_store_pkg::mem_port_t port_b,
    output logic                      rd_valid,
    output logic [`SLOT_TAG_BITS-1:0] rd_tag
);

    import slot_store_pkg::*;

    logic     put_v;
    logic     get_v;
    logic     take_v;
    put_req_t put_q;
    get_req_t get_q;

    //////////////////////////////
    // Input registers
    //////////////////////////////

    // Strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            put_v  <= 1'b0;
            get_v  <= 1'b0;
            take_v <= 1'b0;
        end else begin
            put_v  <= put_valid;
            get_v  <= get_valid;
            take_v <= get_valid && get.take;
        end
    end

    // Request words
    always_ff @(posedge clk) begin
        put_q <= put;
        get_q <= get;
    end

    //////////////////////////////
    // Port words
    //////////////////////////////

    always_comb begin
        // Put sets the slot valid
        port_a.we            = put_v;
        port_a.addr          = put_q.index;
        port_a.entry.valid   = 1'b1;
        port_a.entry.payload = put_q.payload;

        // Get always reads, writes only to clear on a take
        port_b.we            = take_v;
        port_b.addr          = get_q.index;
        port_b.entry.valid   = 1'b0;
        port_b.entry.payload = '0;
    end

    assign rd_valid = get_v;
    assign rd_tag   = get_q.tag;

endmodule

/* list.f */
+incdir+.
slot_store_pkg.sv
ram0.sv
single_ram.sv
cmd_decode.sv
resp_stage.sv
slot_store_top.sv
slot_store_assertions.sv
slot_store_checker.sv
tb_slot_store.sv

/* ram0.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module ram0 #(
    parameter int DWIDTH = `SLOT_PAYLOAD_BITS,
    parameter int AWIDTH = `SLOT_ADDR_BITS,
    parameter RAM_TYPE = "block"
) (
    input  logic              wrclk,
    input  logic [DWIDTH-1:0] di,
    input  logic              wren,
    input  logic [AWIDTH-1:0] wraddr,
    input  logic              rdclk,
    input  logic              rden,
    input  logic [AWIDTH-1:0] rdaddr,
    output logic [DWIDTH-1:0] do_out
);

    localparam int DEPTH = 2 ** AWIDTH;

    (* ram_style = RAM_TYPE *) logic [DWIDTH-1:0] mem [DEPTH];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge wrclk) begin
        if (wren) begin
            mem[wraddr] <= di;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Registered read, old data on a same-address write
    always_ff @(posedge rdclk) begin
        if (rden) begin
            do_out <= mem[rdaddr];
        end
    end

endmodule

/* resp_stage.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module resp_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rd_valid,
    input  logic [`SLOT_TAG_BITS-1:0]   rd_tag,
    input  slot_store_pkg::slot_entry_t rd_entry,
    output logic                        resp_valid,
    output slot_store_pkg::get_resp_t   resp,
    output logic [`SLOT_CNT_BITS-1:0]   hit_count,
    output logic [`SLOT_CNT_BITS-1:0]   miss_count
);

    // Lookup info aligned with the memory read
    logic                      valid_d;
    logic [`SLOT_TAG_BITS-1:0] tag_d;

    //////////////////////////////
    // Control and statistics
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d    <= 1'b0;
            resp_valid <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            valid_d    <= rd_valid;
            resp_valid <= valid_d;
            // Counters wrap
            if (valid_d) begin
                if (rd_entry.valid) begin
                    hit_count <= hit_count + 1'b1;
                end else begin
                    miss_count <= miss_count + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Response word
    //////////////////////////////

    always_ff @(posedge clk) begin
        tag_d        <= rd_tag;
        resp.tag     <= tag_d;
        resp.hit     <= rd_entry.valid;
        resp.payload <= rd_entry.payload;   // stale on a miss
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the slot store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_slot_store -Mdir obj_dir -o sim_slot_store -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_slot_store > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* single_ram.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module single_ram #(
    parameter int PAYLOAD_BITS = `SLOT_PAYLOAD_BITS,
    parameter int NUM_ADDR_BITS = `SLOT_ADDR_BITS,
    parameter RAM_TYPE = "block"
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wea,
    input  logic                        web,
    input  logic [NUM_ADDR_BITS-1:0]    addra,
    input  logic [NUM_ADDR_BITS-1:0]    addrb,
    input  slot_store_pkg::slot_entry_t dina,
    input  slot_store_pkg::slot_entry_t dinb,
    output slot_store_pkg::slot_entry_t doutb
);

    localparam int DEPTH = 2 ** NUM_ADDR_BITS;

    logic                    valid_q;
    logic [PAYLOAD_BITS-1:0] rd_payload;

    //////////////////////////////
    // Valid bits
    //////////////////////////////

    (* ram_style = "distributed" *) logic vld_mem [DEPTH];

    // All slots start empty
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            vld_mem[i] = 1'b0;
        end
    end

    // Port b clears, port a sets
    always @(posedge clk) begin
        if (web) begin
            vld_mem[addrb] <= dinb.valid;
        end
        // Issued last so port a wins on a shared address
        if (wea) begin
            vld_mem[addra] <= dina.valid;
        end
    end

    // Read-first, same timing as the payload read
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= vld_mem[addrb];
        end
    end

    //////////////////////////////
    // Payload memory
    //////////////////////////////

    ram0 #(
        .DWIDTH   (PAYLOAD_BITS),
        .AWIDTH   (NUM_ADDR_BITS),
        .RAM_TYPE (RAM_TYPE)
    ) dat_mem (
        .wrclk  (clk),
        .di     (dina.payload),
        .wren   (wea),
        .wraddr (addra),
        .rdclk  (clk),
        .rden   (1'b1),
        .rdaddr (addrb),
        .do_out (rd_payload)
    );

    assign doutb.valid   = valid_q;
    assign doutb.payload = rd_payload;

endmodule

/* slot_store_assertions.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module slot_store_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      get_valid,
    input logic                      resp_valid,
    input logic [`SLOT_CNT_BITS-1:0] hit_count,
    input logic [`SLOT_CNT_BITS-1:0] miss_count
);

    // Three-cycle latency in both directions
    get_gives_resp: assert property (@(posedge clk) disable iff (reset)
        $past(get_valid, 3) |-> resp_valid)
        else $error("get_valid not followed by resp_valid three cycles later");

    resp_needs_get: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> $past(get_valid, 3))
        else $error("resp_valid without a get three cycles earlier");

    quiet_in_reset: assert property (@(posedge clk) $past(reset) |-> !resp_valid)
        else $error("resp_valid high during reset");

    // Statistics move only with a response
    counters_hold: assert property (@(posedge clk) disable iff (reset)
        !resp_valid |-> $stable(hit_count) && $stable(miss_count))
        else $error("hit or miss counter changed without a response");

endmodule

bind slot_store_top slot_store_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .get_valid  (get_valid),
    .resp_valid (resp_valid),
    .hit_count  (hit_count),
    .miss_count (miss_count)
);

/* slot_store_checker.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module slot_store_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      put_valid,
    input  slot_store_pkg::put_req_t  put,
    input  logic                      get_valid,
    input  slot_store_pkg::get_req_t  get,
    input  logic                      table_hit,
    input  logic                      resp_valid,
    input  slot_store_pkg::get_resp_t resp,
    input  logic [`SLOT_CNT_BITS-1:0] hit_count,
    input  logic [`SLOT_CNT_BITS-1:0] miss_count,
    output int                        errors,
    output int                        checks
);

    import slot_store_pkg::*;

    localparam int SLOTS = 2 ** `SLOT_ADDR_BITS;

    logic [`SLOT_PAYLOAD_BITS-1:0] model_payload [SLOTS];
    logic                          model_valid [SLOTS];
    get_resp_t                     exp_q [$];
    get_resp_t                     exp_r;
    int                            model_hits;
    int                            model_misses;

    task automatic compare_value(input string name, input logic [63:0] expv,
                                 input logic [63:0] got);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("ERROR %s expected 0x%0h got 0x%0h", name, expv, got);
        end
    endtask

    //////////////////////////////
    // Slot model and compare
    //////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            // Every slot empty at start
            for (int i = 0; i < SLOTS; i++) begin
                model_valid[i] = 1'b0;
            end
            exp_q.delete();
            model_hits   = 0;
            model_misses = 0;
            errors       = 0;
            checks       = 0;
        end else begin
            if (resp_valid && exp_q.size() == 0) begin
                errors++;
                $display("response with tag 0x%h arrived with no get outstanding", resp.tag);
            end else if (resp_valid) begin
                exp_r = exp_q.pop_front();
                compare_value("resp.tag", 64'(exp_r.tag), 64'(resp.tag));
                compare_value("resp.hit", 64'(exp_r.hit), 64'(resp.hit));
                if (exp_r.hit) begin
                    compare_value("resp.payload", 64'(exp_r.payload), 64'(resp.payload));
                end
            end
            // Get sees the slot as it was before this cycle's writes
            if (get_valid) begin
                exp_r.tag     = get.tag;
                exp_r.hit     = model_valid[get.index];
                exp_r.payload = model_payload[get.index];
                if (exp_r.hit != table_hit) begin
                    errors++;
                    $display("stimulus row with tag 0x%h expects hit %0d, slot model gives %0d",
                             get.tag, table_hit, exp_r.hit);
                end
                if (exp_r.hit) begin
                    model_hits++;
                end else begin
                    model_misses++;
                end
                exp_q.push_back(exp_r);
                if (get.take) begin
                    model_valid[get.index] = 1'b0;
                end
            end
            // Put last, it wins over a take of the same slot
            if (put_valid) begin
                model_valid[put.index]   = 1'b1;
                model_payload[put.index] = put.payload;
            end
        end
    end

    task automatic wait_idle(input int limit, output bit ok);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (exp_q.size() != 0 && n < limit);
        ok = (exp_q.size() == 0);
        if (!ok) begin
            $display("timeout, %0d responses still outstanding after %0d cycles",
                     exp_q.size(), limit);
        end
    endtask

    task automatic check_counters(output int bad);
        bad = 0;
        if (hit_count !== model_hits[`SLOT_CNT_BITS-1:0]) begin
            bad++;
            $display("ERROR hit_count expected 0x%h got 0x%h",
                     model_hits[`SLOT_CNT_BITS-1:0], hit_count);
        end
        if (miss_count !== model_misses[`SLOT_CNT_BITS-1:0]) begin
            bad++;
            $display("ERROR miss_count expected 0x%h got 0x%h",
                     model_misses[`SLOT_CNT_BITS-1:0], miss_count);
        end
    endtask

endmodule

/* slot_store_macros.svh */
`ifndef SLOT_STORE_MACROS_SVH
`define SLOT_STORE_MACROS_SVH

//////////////////////////////
// Slot store widths
//////////////////////////////

// Stored word, valid bit not included
`define SLOT_PAYLOAD_BITS 32

// Slot index, 128 slots
`define SLOT_ADDR_BITS 7

// Tag carried by a get
`define SLOT_TAG_BITS 4

// Hit and miss statistics
`define SLOT_CNT_BITS 16

`endif

/* slot_store_pkg.sv */
`include "slot_store_macros.svh"

package slot_store_pkg;

    //////////////////////////////
    // Requests
    //////////////////////////////

    // Producer deposit
    typedef struct packed {
        logic [`SLOT_ADDR_BITS-1:0]    index;
        logic [`SLOT_PAYLOAD_BITS-1:0] payload;
    } put_req_t;

    // Consumer lookup, take clears the slot
    typedef struct packed {
        logic [`SLOT_ADDR_BITS-1:0] index;
        logic                       take;
        logic [`SLOT_TAG_BITS-1:0]  tag;
    } get_req_t;

    //////////////////////////////
    // Storage words
    //////////////////////////////

    // Valid bit sits above the payload
    typedef struct packed {
        logic                          valid;
        logic [`SLOT_PAYLOAD_BITS-1:0] payload;
    } slot_entry_t;

    // One memory port
    typedef struct packed {
        logic                       we;
        logic [`SLOT_ADDR_BITS-1:0] addr;
        slot_entry_t                entry;
    } mem_port_t;

    // Get result back to the consumer
    typedef struct packed {
        logic [`SLOT_TAG_BITS-1:0]     tag;
        logic                          hit;
        logic [`SLOT_PAYLOAD_BITS-1:0] payload;
    } get_resp_t;

endpackage

/* slot_store_top.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module slot_store_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      put_valid,
    input  slot_store_pkg::put_req_t  put,
    input  logic                      get_valid,
    input  slot_store_pkg::get_req_t  get,
    output logic                      resp_valid,
    output slot_store_pkg::get_resp_t resp,
    output logic [`SLOT_CNT_BITS-1:0] hit_count,
    output logic [`SLOT_CNT_BITS-1:0] miss_count
);

    import slot_store_pkg::*;

    mem_port_t                 port_a;
    mem_port_t                 port_b;
    logic                      rd_valid;
    logic [`SLOT_TAG_BITS-1:0] rd_tag;
    slot_entry_t               rd_entry;

    //////////////////////////////
    // Stage 1, command
    //////////////////////////////

    cmd_decode u_cmd (
        .clk       (clk),
        .reset     (reset),
        .put_valid (put_valid),
        .put       (put),
        .get_valid (get_valid),
        .get       (get),
        .port_a    (port_a),
        .port_b    (port_b),
        .rd_valid  (rd_valid),
        .rd_tag    (rd_tag)
    );

    //////////////////////////////
    // Stage 2, storage
    //////////////////////////////

    single_ram #(
        .PAYLOAD_BITS  (`SLOT_PAYLOAD_BITS),
        .NUM_ADDR_BITS (`SLOT_ADDR_BITS),
        .RAM_TYPE      ("block")
    ) u_ram (
        .clk   (clk),
        .reset (reset),
        .wea   (port_a.we),
        .web   (port_b.we),
        .addra (port_a.addr),
        .addrb (port_b.addr),
        .dina  (port_a.entry),
        .dinb  (port_b.entry),
        .doutb (rd_entry)
    );

    //////////////////////////////
    // Stage 3, response
    //////////////////////////////

    resp_stage u_resp (
        .clk        (clk),
        .reset      (reset),
        .rd_valid   (rd_valid),
        .rd_tag     (rd_tag),
        .rd_entry   (rd_entry),
        .resp_valid (resp_valid),
        .resp       (resp),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

/* tb_slot_store.sv */
`timescale 1ns/1ps
`include "slot_store_macros.svh"

module tb_slot_store;

    import slot_store_pkg::*;

    localparam int K_PUT       = 0;
    localparam int K_GET       = 1;
    localparam int K_BOTH      = 2;
    localparam int DRAIN_LIMIT = 20;

    // One stimulus row with its expected hit
    typedef struct packed {
        int kind;
        int index;
        int take;
        int tag;
        int gap;
        int hit;
        int test_id;
    } row_t;

    logic                      clk;
    logic                      reset;
    logic                      put_valid;
    put_req_t                  put;
    logic                      get_valid;
    get_req_t                  get;
    logic                      table_hit;
    logic                      resp_valid;
    get_resp_t                 resp;
    logic [`SLOT_CNT_BITS-1:0] hit_count;
    logic [`SLOT_CNT_BITS-1:0] miss_count;
    int                        errors;
    int                        checks;

    row_t        rows [$];
    string       test_names [6];
    logic [31:0] rand_state;
    int          tests;
    int          fails;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    slot_store_top uut (
        .clk        (clk),
        .reset      (reset),
        .put_valid  (put_valid),
        .put        (put),
        .get_valid  (get_valid),
        .get        (get),
        .resp_valid (resp_valid),
        .resp       (resp),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    slot_store_checker u_chk (
        .clk        (clk),
        .reset      (reset),
        .put_valid  (put_valid),
        .put        (put),
        .get_valid  (get_valid),
        .get        (get),
        .table_hit  (table_hit),
        .resp_valid (resp_valid),
        .resp       (resp),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .errors     (errors),
        .checks     (checks)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    // kind, index, take, tag, gap, hit, test
    task automatic build_table();
        test_names[0] = "miss then hit";
        test_names[1] = "take clears slot";
        test_names[2] = "get and put same cycle";
        test_names[3] = "put and take same cycle";
        test_names[4] = "back-to-back gets";
        test_names[5] = "final counters";
        rows.push_back('{K_GET, 5, 0, 1, 0, 0, 1});
        rows.push_back('{K_PUT, 5, 0, 0, 0, 0, 1});
        rows.push_back('{K_GET, 5, 0, 2, 0, 1, 1});
        rows.push_back('{K_PUT, 9, 0, 0, 0, 0, 2});
        rows.push_back('{K_GET, 9, 1, 3, 0, 1, 2});
        rows.push_back('{K_GET, 9, 0, 4, 0, 0, 2});
        rows.push_back('{K_GET, 9, 0, 5, 2, 0, 2});
        rows.push_back('{K_PUT, 9, 0, 0, 0, 0, 2});
        rows.push_back('{K_GET, 9, 0, 6, 0, 1, 2});
        rows.push_back('{K_PUT, 20, 0, 0, 0, 0, 3});
        rows.push_back('{K_BOTH, 20, 0, 7, 0, 1, 3});
        rows.push_back('{K_GET, 20, 0, 8, 0, 1, 3});
        rows.push_back('{K_PUT, 33, 0, 0, 0, 0, 4});
        rows.push_back('{K_BOTH, 33, 1, 9, 0, 1, 4});
        rows.push_back('{K_GET, 33, 0, 10, 0, 1, 4});
        rows.push_back('{K_GET, 33, 1, 11, 0, 1, 4});
        rows.push_back('{K_GET, 33, 0, 12, 0, 0, 4});
        rows.push_back('{K_PUT, 40, 0, 0, 0, 0, 5});
        rows.push_back('{K_PUT, 41, 0, 0, 0, 0, 5});
        rows.push_back('{K_PUT, 42, 0, 0, 0, 0, 5});
        rows.push_back('{K_GET, 40, 0, 13, 0, 1, 5});
        rows.push_back('{K_GET, 41, 0, 14, 0, 1, 5});
        rows.push_back('{K_GET, 42, 0, 15, 0, 1, 5});
        rows.push_back('{K_GET, 43, 0, 0, 0, 0, 5});
        rows.push_back('{K_GET, 5, 0, 1, 0, 1, 5});
    endtask

    task automatic drive_row(input row_t r);
        rand_state = xorshift32(rand_state);
        put_valid   <= (r.kind != K_GET);
        put.index   <= r.index[`SLOT_ADDR_BITS-1:0];
        put.payload <= rand_state;
        get_valid   <= (r.kind != K_PUT);
        get.index   <= r.index[`SLOT_ADDR_BITS-1:0];
        get.take    <= r.take[0];
        get.tag     <= r.tag[`SLOT_TAG_BITS-1:0];
        table_hit   <= r.hit[0];
    endtask

    task automatic drive_idle();
        put_valid <= 1'b0;
        get_valid <= 1'b0;
    endtask

    task automatic finish_test(input int id, input bit passed);
        tests++;
        if (!passed) begin
            fails++;
        end
        $display("test %0d %s: %s", id, test_names[id - 1], passed ? "passed" : "failed");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        bit ok;
        bit stop;
        int err_start;
        int bad;

        reset      = 1'b1;
        put_valid  = 1'b0;
        put        = '0;
        get_valid  = 1'b0;
        get        = '0;
        table_hit  = 1'b0;
        rand_state = 32'd74;
        tests      = 0;
        fails      = 0;
        stop       = 1'b0;
        build_table();

        // Gets during reset are dropped and raise no response
        repeat (2) @(posedge clk);
        get_valid <= 1'b1;
        repeat (4) @(posedge clk);
        get_valid <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        err_start = errors;

        for (int i = 0; i < rows.size() && !stop; i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            for (int g = 0; g < rows[i].gap; g++) begin
                @(posedge clk);
                drive_idle();
            end
            // Let the pipeline drain after the last row of a test
            if (i == rows.size() - 1 || rows[i + 1].test_id != rows[i].test_id) begin
                @(posedge clk);
                drive_idle();
                u_chk.wait_idle(DRAIN_LIMIT, ok);
                finish_test(rows[i].test_id, ok && errors == err_start);
                err_start = errors;
                stop      = !ok;
            end
        end

        if (!stop) begin
            u_chk.check_counters(bad);
            finish_test(6, bad == 0);
        end

        $display("tests %0d, failed %0d, responses checked %0d, mismatches %0d",
                 tests, fails, checks, errors);
        if (fails == 0 && !stop) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
